//--- compile.f
+incdir+rtl
rtl/video_timing_pkg.sv
rtl/pixel_pkg.sv
rtl/pixel_capture.sv
rtl/frame_buffer.sv
rtl/color_grade.sv
rtl/scanout.sv
rtl/gba_video_top.sv
tb/tb_gba_video.sv

//--- Makefile
# Verilator build and run of the video path testbench

TOP = tb_gba_video

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing --top-module $(TOP) -f compile.f

# Run, keep the log, pass only if the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_gba_video.sv
//========================================
// Directed testbench for the video path
// Reset, raster timing, frame data, desaturation, pause, restart
//========================================
`default_nettype none

`include "video_cfg.svh"

module tb_gba_video;

	import video_timing_pkg::*;
	import pixel_pkg::*;

	localparam int line_clks  = `H_TOTAL * `CE_DIV;
	localparam int frame_clks = `V_TOTAL_SYNC * line_clks;

	logic        clk_sys = 1'b0;
	logic        reset;
	fb_addr_t    pixel_addr;
	rgb666_t     pixel_data;
	logic        pixel_we;
	logic        sync_core;
	logic        fast_forward;
	color_mode_t color_mode;
	logic        ce_pix;
	logic        hs;
	logic        vs;
	logic        hblank;
	logic        vblank;
	logic        force_pause;
	rgb888_t     rgb;

	int      errors = 0;
	int      checks = 0;
	int      cycles = 0;                 // clk_sys count for period checks
	bit      stalled = 1'b0;             // Set once a wait runs out
	integer  seed = 32'hb24e_cc94;
	rgb666_t shadow [0:`FB_WORDS-1];     // What the buffer should hold

	gba_video_top UUT (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pixel_addr   (pixel_addr),
		.pixel_data   (pixel_data),
		.pixel_we     (pixel_we),
		.sync_core    (sync_core),
		.fast_forward (fast_forward),
		.color_mode   (color_mode),
		.ce_pix       (ce_pix),
		.hs           (hs),
		.vs           (vs),
		.hblank       (hblank),
		.vblank       (vblank),
		.rgb          (rgb),
		.force_pause  (force_pause)
	);

	initial begin
		forever #10 clk_sys = ~clk_sys;   // Period 20
	end

	always @(posedge clk_sys) cycles <= cycles + 1;

	//========================================
	// Compare tasks
	//========================================
	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_rgb(input string name, input rgb888_t got, input rgb888_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("** Error %s: got %h expected %h", name, got, exp);
		end
	endtask

	//========================================
	// Reference colour model
	//========================================
	function automatic logic [7:0] mix_channel(input int x, input int y, input color_mode_t mode);
		int v;
		case (mode)
			3'd5:    v = x / 2 + x / 4 + y / 4;   // Mild
			3'd6:    v = x / 2 + y / 2;           // Half
			3'd7:    v = y / 2 + y / 4 + x / 4;   // Strong
			default: v = x;
		endcase
		v = v % 256;                              // 8-bit wrap
		return v[7:0];
	endfunction

	function automatic rgb888_t graded_colour(input rgb666_t p, input color_mode_t mode);
		int      r8;
		int      g8;
		int      b8;
		int      y;
		rgb888_t res;
		r8 = int'({p.r, p.r[5:4]});               // Top bits repeated below
		g8 = int'({p.g, p.g[5:4]});
		b8 = int'({p.b, p.b[5:4]});
		y  = (r8 / 4 + g8 / 2 + g8 / 8 + b8 / 8) % 256;
		res.r = mix_channel(r8, y, mode);
		res.g = mix_channel(g8, y, mode);
		res.b = mix_channel(b8, y, mode);
		return res;
	endfunction

	//========================================
	// Waits, each with its own limit
	//========================================
	task automatic note_timeout(input string what);
		errors++;
		stalled = 1'b1;                           // Later waits return at once
		$display("Timeout while waiting for %s", what);
	endtask

	task automatic wait_enable();
		int n;
		n = 0;
		if (!stalled) begin
			@(negedge clk_sys);
			while (!ce_pix && n < 4 * `CE_DIV) begin
				@(negedge clk_sys);
				n++;
			end
			if (!ce_pix) note_timeout("ce_pix");
		end
	endtask

	task automatic wait_vblank(input logic level, input int limit);
		int n;
		n = 0;
		if (!stalled) begin
			while (vblank !== level && n < limit) begin
				@(negedge clk_sys);
				n++;
			end
			if (vblank !== level) note_timeout("vblank");
		end
	endtask

	task automatic wait_pause(input int limit);
		int n;
		n = 0;
		if (!stalled) begin
			while (force_pause !== 1'b1 && n < limit) begin
				@(negedge clk_sys);
				n++;
			end
			if (force_pause !== 1'b1) note_timeout("force_pause to rise");
		end
	endtask

	// Land at the top of the bottom blank, the longest write window
	task automatic reach_bottom_blank();
		wait_vblank(1'b0, frame_clks);
		wait_vblank(1'b1, frame_clks);
	endtask

	//========================================
	// Core-side writes
	//========================================
	task automatic write_pixel(input fb_addr_t addr, input rgb666_t data);
		shadow[addr] = data;
		pixel_addr   = addr;
		pixel_data   = data;
		pixel_we     = 1'b1;
		@(negedge clk_sys);
		pixel_we     = 1'b0;
	endtask

	task automatic fill_frame(input bit use_random, input rgb666_t colour);
		int          a;
		logic [31:0] r;
		rgb666_t     p;
		for (a = 0; a < `FB_WORDS; a++) begin
			r = $random(seed);
			p = use_random ? r[17:0] : colour;
			shadow[a]  = p;
			pixel_addr = fb_addr_t'(a);
			pixel_data = p;
			pixel_we   = 1'b1;                    // Back to back, one per clock
			@(negedge clk_sys);
		end
		pixel_we = 1'b0;
	endtask

	// Next frame's active pixels against the shadow, in address order
	task automatic scan_frame(input color_mode_t mode);
		int k;
		int guard;
		wait_vblank(1'b1, frame_clks);
		color_mode = mode;                        // Only changed while blanked
		wait_vblank(1'b0, frame_clks);
		k = 0;
		guard = 0;
		while (k < `FB_WORDS && guard < `V_ACTIVE * `H_TOTAL && !stalled) begin
			if (!hblank && !vblank) begin
				check_rgb($sformatf("rgb pixel %0d", k), rgb, graded_colour(shadow[k], mode));
				k++;
			end
			guard++;
			wait_enable();
		end
		if (k < `FB_WORDS && !stalled) begin
			errors++;
			$display("Active area ended after %0d of %0d pixels", k, `FB_WORDS);
		end
	endtask

	//========================================
	// Directed tests
	//========================================
	task automatic reset_state();
		reset = 1'b1;
		repeat (10) @(negedge clk_sys);
		check_bit("hs", hs, 1'b0);              // Reset values, no writes yet
		check_bit("vs", vs, 1'b0);
		check_bit("ce_pix", ce_pix, 1'b0);
		check_bit("force_pause", force_pause, 1'b0);
		check_bit("hblank", hblank, 1'b1);
		check_bit("vblank", vblank, 1'b1);
		reset = 1'b0;
	endtask

	task automatic measure_raster();
		int   t0;
		int   k;
		int   rises;
		int   first_rise;
		int   second_rise;
		int   hs_len;
		int   active;
		logic hs_prev;
		wait_enable();
		t0 = cycles;
		repeat (4) begin
			wait_enable();
			check_count("ce_pix period", cycles - t0, `CE_DIV);
			t0 = cycles;
		end
		hs_prev = hs;
		rises = 0;
		k = 0;
		first_rise = 0;
		second_rise = 0;
		hs_len = 0;
		active = 0;
		// One full line between two hs rises
		while (rises < 2 && k < 3 * `H_TOTAL && !stalled) begin
			wait_enable();
			k++;
			if (hs && !hs_prev) begin
				rises++;
				if (rises == 1) first_rise = k;
				else second_rise = k;
			end
			if (rises == 1 && hs) hs_len++;
			if (rises == 1 && !hblank) active++;
			hs_prev = hs;
		end
		if (rises < 2) begin
			errors++;
			$display("hs did not rise twice within three lines");
		end else begin
			check_count("hs period", second_rise - first_rise, `H_TOTAL);
			check_count("hs width", hs_len, `HS_WIDTH);
			check_count("hblank low enables", active, `H_ACTIVE);
		end
	endtask

	task automatic tearing_pause();
		int n;
		bit counting;
		sync_core    = 1'b1;
		fast_forward = 1'b0;
		write_pixel(fb_addr_t'(100), shadow[100]);   // Core still near the top
		wait_pause(frame_clks + line_clks);
		n = 0;
		counting = !stalled;
		while (counting) begin
			wait_enable();
			if (force_pause) n++;
			counting = force_pause && n <= `PAUSE_CE + 8 && !stalled;
		end
		check_count("force_pause enables", n, `PAUSE_CE + 1);
		fast_forward = 1'b1;                     // Pause must not start now
		wait_vblank(1'b1, frame_clks);
		wait_vblank(1'b0, frame_clks);
		check_bit("force_pause", force_pause, 1'b0);
		fast_forward = 1'b0;
	endtask

	task automatic free_run_restart();
		int   lines;
		int   n;
		int   vs_on;
		int   vs_off;
		logic hs_prev;
		logic vs_prev;
		sync_core = 1'b0;
		wait_vblank(1'b1, frame_clks);
		write_pixel('0, shadow[0]);              // Frame start from the core
		lines = 0;
		n = 0;
		vs_on = 0;
		vs_off = 0;
		hs_prev = hs;
		vs_prev = vs;
		while (vblank && n < (`V_START + 4) * line_clks && !stalled) begin
			@(negedge clk_sys);
			n++;
			if (hs && !hs_prev) lines++;          // One hs per line
			if (vs && !vs_prev) vs_on = lines;    // hs rises so far, line 0 included
			if (!vs && vs_prev) vs_off = lines;
			hs_prev = hs;
			vs_prev = vs;
		end
		if (!stalled) begin
			if (vblank) begin
				note_timeout("vblank to fall after restart");
			end else begin
				if (lines < `V_START - 1 || lines > `V_START) begin
					errors++;
					$display("** Error lines to vblank fall: got %h expected %h to %h",
						lines, `V_START - 1, `V_START);
				end
				check_count("vs rise line", vs_on, `VS_ON_LINE + 1);
				check_count("vs fall line", vs_off, `VS_OFF_LINE + 1);
			end
		end
		checks++;
		sync_core = 1'b1;
	endtask

	//========================================
	// Sequence and summary
	//========================================
	initial begin
		reset        = 1'b1;
		pixel_addr   = '0;
		pixel_data   = '0;
		pixel_we     = 1'b0;
		sync_core    = 1'b1;
		fast_forward = 1'b0;
		color_mode   = '0;

		reset_state();
		measure_raster();

		reach_bottom_blank();                    // Random frame, plain colour
		fill_frame(1'b1, '0);
		scan_frame(3'd0);

		reach_bottom_blank();                    // Flat colour, three blends
		fill_frame(1'b0, rgb666_t'($random(seed)));
		scan_frame(3'd5);
		scan_frame(3'd6);
		scan_frame(3'd7);
		color_mode = 3'd0;

		tearing_pause();
		free_run_restart();

		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/gba_video_top.sv
//========================================
// Video path top level
// Writer, frame RAM and scanout
//========================================
`default_nettype none

module gba_video_top (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire video_timing_pkg::fb_addr_t pixel_addr,
	input  wire pixel_pkg::rgb666_t         pixel_data,
	input  wire                             pixel_we,
	input  wire                             sync_core,
	input  wire                             fast_forward,
	input  wire pixel_pkg::color_mode_t     color_mode,
	output logic                            ce_pix,
	output logic                            hs,
	output logic                            vs,
	output logic                            hblank,
	output logic                            vblank,
	output pixel_pkg::rgb888_t              rgb,
	output logic                            force_pause
);

	import video_timing_pkg::*;
	import pixel_pkg::*;

	fb_addr_t wr_addr;      // Writer to RAM
	rgb666_t  wr_data;
	logic     wr_en;
	logic     frame_sync;   // Writer to scanout
	fb_addr_t last_addr;
	fb_addr_t rd_addr;      // Scanout to RAM and back
	rgb666_t  rd_data;

	pixel_capture u_capture (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pixel_addr (pixel_addr),
		.pixel_data (pixel_data),
		.pixel_we   (pixel_we),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.wr_en      (wr_en),
		.frame_sync (frame_sync),
		.last_addr  (last_addr)
	);

	frame_buffer #(.word_t(rgb666_t)) u_fb (
		.clk_sys (clk_sys),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	scanout u_scanout (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.frame_sync   (frame_sync),
		.last_addr    (last_addr),
		.sync_core    (sync_core),
		.fast_forward (fast_forward),
		.color_mode   (color_mode),
		.rd_addr      (rd_addr),
		.rd_data      (rd_data),
		.ce_pix       (ce_pix),
		.hs           (hs),
		.vs           (vs),
		.hblank       (hblank),
		.vblank       (vblank),
		.force_pause  (force_pause),
		.rgb          (rgb)
	);

endmodule

`default_nettype wire

//--- rtl/scanout.sv
//========================================
// Raster counters, sync and blank, frame-RAM read
// addressing, free-run restart and tearing pause
//========================================
`default_nettype none

`include "video_cfg.svh"

module scanout (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire                             frame_sync,    // Frame start from the writer
	input  wire video_timing_pkg::fb_addr_t last_addr,
	input  wire                             sync_core,     // Core locked to video
	input  wire                             fast_forward,
	input  wire pixel_pkg::color_mode_t     color_mode,
	output video_timing_pkg::fb_addr_t      rd_addr,
	input  wire pixel_pkg::rgb666_t         rd_data,
	output logic                            ce_pix,
	output logic                            hs,
	output logic                            vs,
	output logic                            hblank,
	output logic                            vblank,
	output logic                            force_pause,   // Hold the core off the buffer
	output pixel_pkg::rgb888_t              rgb
);

	import video_timing_pkg::*;
	import pixel_pkg::*;

	localparam int div_w = $clog2(`CE_DIV);
	localparam logic [div_w-1:0] div_last = div_w'(`CE_DIV - 1);
	localparam h_count_t h_last  = h_count_t'(`H_TOTAL - 1);
	localparam h_count_t hs_stop = h_count_t'(`HS_START + `HS_WIDTH);
	localparam v_count_t v_end   = v_count_t'(`V_START + `V_ACTIVE);   // First bottom-blank line
	localparam v_count_t v_wrap  = v_count_t'(`V_TOTAL_SYNC - 1);
	localparam v_count_t v_pause = v_count_t'(`V_START - 1);           // Line before the picture
	localparam fb_addr_t pause_addr = fb_addr_t'(`PAUSE_LINES * `H_ACTIVE);

	logic [div_w-1:0] div;       // Pixel divider
	logic             ce_tick;   // Cycle before ce_pix, outputs load here
	logic             frame_sync_d;
	logic             restart;
	h_count_t         x;
	v_count_t         y;
	pause_count_t     pause_cnt;
	rgb666_t          pix_q;     // Buffer word on display

	assign ce_tick = (div == '0);

	// Free-running mode follows the core's frame start, only while blanked
	assign restart = frame_sync && !frame_sync_d && !sync_core && vblank;

	//========================================
	// Pixel enable
	//========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div          <= '0;
			ce_pix       <= 1'b0;
			frame_sync_d <= 1'b0;
		end else begin
			div          <= (div == div_last) ? '0 : div + 1'b1;
			ce_pix       <= ce_tick;
			frame_sync_d <= frame_sync;       // Edge detect
		end
	end

	// Position counters, advance at the end of each enable
	always_ff @(posedge clk_sys) begin
		if (reset || restart) begin
			x <= '0;
			y <= '0;
		end else if (ce_pix) begin
			if (x == h_last) begin
				x <= '0;
				if (sync_core && y >= v_wrap)
					y <= '0;                  // Locked frame length
				else if (~&y)
					y <= y + 1'b1;            // Free run waits at the top
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	//========================================
	// Sync and blank
	//========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hs     <= 1'b0;
			vs     <= 1'b0;
			hblank <= 1'b1;
			vblank <= 1'b1;
		end else begin
			if (ce_tick) begin
				if (x == h_count_t'(`H_ACTIVE)) hblank <= 1'b1;
				if (x == '0)                    hblank <= 1'b0;

				if (x == h_count_t'(`HS_START)) begin
					hs <= 1'b1;
					if (y == v_count_t'(`VS_ON_LINE))  vs <= 1'b1;   // vs edges ride on hs
					if (y == v_count_t'(`VS_OFF_LINE)) vs <= 1'b0;
				end
				if (x == hs_stop) hs <= 1'b0;

				if (y == v_count_t'(`V_START)) vblank <= 1'b0;
				if (y >= v_end)                vblank <= 1'b1;
			end
			if (restart) begin
				hs <= 1'b0;
				vs <= 1'b0;
			end
		end
	end

	// Read address runs one word ahead of the displayed pixel
	always_ff @(posedge clk_sys) begin
		if (reset)
			rd_addr <= '0;
		else if (ce_pix) begin
			if (vblank)
				rd_addr <= '0;                // Rewind for the next frame
			else if (!hblank)
				rd_addr <= rd_addr + 1'b1;
		end
	end

	// Capture the word read in the previous cycle
	always_ff @(posedge clk_sys) begin
		if (ce_tick)
			pix_q <= rd_data;
	end

	//========================================
	// Tearing pause
	//========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			force_pause <= 1'b0;
			pause_cnt   <= '0;
		end else if (ce_pix) begin
			if (x == h_last && y == v_pause) begin
				// Core still near the top, stall it until scanout is ahead
				force_pause <= sync_core && !fast_forward && (last_addr < pause_addr);
				pause_cnt   <= pause_count_t'(`PAUSE_CE);
			end else if (force_pause) begin
				if (pause_cnt != '0)
					pause_cnt <= pause_cnt - 1'b1;
				else
					force_pause <= 1'b0;      // Extra enable after the count
			end
		end
	end

	color_grade u_grade (
		.pixel_in  (pix_q),
		.mode      (color_mode),
		.pixel_out (rgb)
	);

endmodule

`default_nettype wire

//--- rtl/color_grade.sv
//========================================
// RGB666 to RGB888 expansion
// and luma-blend desaturation
//========================================
`default_nettype none

module color_grade (
	input  wire pixel_pkg::rgb666_t     pixel_in,
	input  wire pixel_pkg::color_mode_t mode,        // Menu colour selection
	output pixel_pkg::rgb888_t          pixel_out
);

	import pixel_pkg::*;

	rgb888_t x8;      // Expanded input
	chan8_t  luma;    // Approximate brightness
	desat_t  desat;   // Decoded blend strength

	// Blend one channel toward luma, all terms wrap at 8 bits
	function automatic chan8_t grade_chan(input chan8_t c, input chan8_t y, input desat_t d);
		case (d)
			desat_mild:   grade_chan = (c >> 1) + (c >> 2) + (y >> 2);
			desat_half:   grade_chan = (c >> 1) + (y >> 1);
			desat_strong: grade_chan = (y >> 1) + (y >> 2) + (c >> 2);
			default:      grade_chan = c;
		endcase
	endfunction

	// Repeat the top bits so full scale stays full scale
	assign x8.r = {pixel_in.r, pixel_in.r[5:4]};
	assign x8.g = {pixel_in.g, pixel_in.g[5:4]};
	assign x8.b = {pixel_in.b, pixel_in.b[5:4]};

	// Roughly 1/4 R + 5/8 G + 1/8 B
	assign luma = (x8.r >> 2) + (x8.g >> 1) + (x8.g >> 3) + (x8.b >> 3);

	//========================================
	// Mode decode
	//========================================
	always_comb begin
		case (mode)
			3'd5:    desat = desat_mild;
			3'd6:    desat = desat_half;
			3'd7:    desat = desat_strong;
			default: desat = desat_off;      // Shader modes are not built here
		endcase
	end

	assign pixel_out.r = grade_chan(x8.r, luma, desat);
	assign pixel_out.g = grade_chan(x8.g, luma, desat);
	assign pixel_out.b = grade_chan(x8.b, luma, desat);

endmodule

`default_nettype wire

//--- rtl/frame_buffer.sv
//========================================
// Dual-port frame RAM
// One write port, one registered read port
//========================================
`default_nettype none

`include "video_cfg.svh"

module frame_buffer #(
	parameter type word_t = pixel_pkg::rgb666_t   // Stored pixel format
) (
	input  wire                             clk_sys,
	input  wire video_timing_pkg::fb_addr_t wr_addr,
	input  wire word_t                      wr_data,
	input  wire                             wr_en,
	input  wire video_timing_pkg::fb_addr_t rd_addr,
	output word_t                           rd_data    // Valid the cycle after rd_addr
);

	// One word per visible pixel
	word_t mem [0:`FB_WORDS-1];

	// Write side, core domain
	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Read side, returns the old word on a same-address collision
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- rtl/pixel_capture.sv
//========================================
// Core-side pixel writer
// Registers writes to the frame RAM, detects frame start
//========================================
`default_nettype none

`include "video_cfg.svh"

module pixel_capture (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire video_timing_pkg::fb_addr_t pixel_addr,   // From the core
	input  wire pixel_pkg::rgb666_t    pixel_data,
	input  wire                        pixel_we,          // One strobe per pixel
	output video_timing_pkg::fb_addr_t wr_addr,           // Toward the frame RAM
	output pixel_pkg::rgb666_t         wr_data,
	output logic                       wr_en,
	output logic                       frame_sync,        // Stretched frame-start pulse
	output video_timing_pkg::fb_addr_t last_addr          // Latest written address
);

	// Pulse stretcher, LSB is the output
	logic [`SYNC_STRETCH-1:0] stretch_sr;

	// Write payload, follows the strobe by one cycle
	always_ff @(posedge clk_sys) begin
		if (pixel_we) begin
			wr_addr <= pixel_addr;
			wr_data <= pixel_data;
		end
	end

	//========================================
	// Write strobe, last address, frame start
	//========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_en      <= 1'b0;
			last_addr  <= '0;
			stretch_sr <= '0;
		end else begin
			wr_en <= pixel_we;
			if (pixel_we)
				last_addr <= pixel_addr;      // Tells scanout how far the core has got

			// Pixel 0 marks a new frame from the core
			if (pixel_we && pixel_addr == '0)
				stretch_sr <= '1;             // Reload, a new start restarts the pulse
			else
				stretch_sr <= stretch_sr >> 1;
		end
	end

	assign frame_sync = stretch_sr[0];    // High for SYNC_STRETCH clocks

endmodule

`default_nettype wire

//--- rtl/pixel_pkg.sv
//========================================
// Pixel formats and colour-mode types
//========================================
`default_nettype none

package pixel_pkg;

	//========================================
	// Channel and pixel formats
	//========================================
	typedef logic [5:0] chan6_t;   // Core-side channel
	typedef logic [7:0] chan8_t;   // Output channel

	// Core pixel as stored in the buffer, red in the top bits
	typedef struct packed {
		chan6_t r;
		chan6_t g;
		chan6_t b;
	} rgb666_t;

	// Pixel as sent to the display
	typedef struct packed {
		chan8_t r;
		chan8_t g;
		chan8_t b;
	} rgb888_t;

	//========================================
	// Colour modes
	//========================================
	// Raw menu selection
	// 5, 6 and 7 are the desaturation entries, the rest show plain colour
	typedef logic [2:0] color_mode_t;

	// Strength of the blend toward luma
	typedef enum logic [1:0] {
		desat_off    = 2'd0,   // Expanded colour passed through
		desat_mild   = 2'd1,   // 3/4 colour, 1/4 luma
		desat_half   = 2'd2,   // Even mix
		desat_strong = 2'd3    // 1/4 colour, 3/4 luma
	} desat_t;

endpackage

`default_nettype wire

//--- rtl/video_timing_pkg.sv
//========================================
// Counter and address types for the raster
// and the frame buffer
//========================================
`default_nettype none

package video_timing_pkg;

	// Horizontal position, 0 .. H_TOTAL-1
	typedef logic [8:0] h_count_t;

	// Line number
	// Saturates at all ones when not locked to the core
	typedef logic [8:0] v_count_t;

	// Word address into the 240x160 buffer
	typedef logic [15:0] fb_addr_t;

	// Remaining enables of the tearing pause
	typedef logic [13:0] pause_count_t;

endpackage

`default_nettype wire

//--- rtl/video_cfg.svh
//========================================
// Raster geometry, frame-buffer size, pixel divider
// and tearing-pause constants for the video path
//========================================
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

//========================================
// Horizontal timing, in pixel enables
//========================================
`define H_ACTIVE      240     // Visible pixels per line
`define H_TOTAL       399     // Enables per line, blank included
`define HS_START      293     // Enable on which hs rises
`define HS_WIDTH      32      // hs pulse length

//========================================
// Vertical timing, in lines
//========================================
`define VS_ON_LINE    1       // vs rises on this line
`define VS_OFF_LINE   4       // and falls on this one
`define V_START       62      // First visible line
`define V_ACTIVE      160     // Visible lines per frame
`define V_TOTAL_SYNC  264     // Frame length when locked to the core

// Pixel clock is a divided enable on clk_sys
`define CE_DIV        8
// Length of the frame-start pulse in clk_sys cycles
`define SYNC_STRETCH  8

// One RGB666 word per visible pixel
`define FB_WORDS      38400

// Tearing pause
// Core is held for 22 of its own lines, rescaled to 399-wide output lines
`define PAUSE_LINES   22
`define PAUSE_CE      10164

`endif
